//--- verilog/aer_arbiter_pkg.sv
package aer_arbiter_pkg;

    localparam int POLARITY   = 2;                  // Width of a pixel polarity code
    localparam int EVT_ADDR_W = 4;                  // Address field width, groups up to 16x16
    localparam int TS_W       = 16;                 // Timestamp width

    // Group FSM states
    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,                          // Arbitration off
        ROW_GRANT = 2'b01,                          // Row arbiter searching
        COL_GRANT = 2'b10                           // Columns of granted row being served
    } arb_state_t;

    // APB register offsets
    typedef enum logic [7:0]
    {
        CTRL   = 8'h00,                             // Bit 0 arbitration enable
        STATUS = 8'h04,                             // Count, overflow, scan count
        EVENT  = 8'h08                              // Pop one event word
    } reg_addr_t;

    typedef struct packed
    {
        logic [TS_W-1:0]       timestamp;           // Time of the grant
        logic [POLARITY-1:0]   polarity;            // Polarity of granted pixel
        logic [EVT_ADDR_W-1:0] y_addr;              // Column address
        logic [EVT_ADDR_W-1:0] x_addr;              // Row address
    } aer_event_t;

    typedef struct packed
    {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed
    {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

//--- verilog/x_roundrobin.sv
`timescale 1ns/10ps

module x_roundrobin
#(
    parameter int Lvl_ROWS    = 4,                  // Number of rows
    parameter int Lvl_ROW_ADD = 2                   // Row address width
)
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,        // Advance to next requesting row
    input  logic                   refresh_i,       // Restart scan at row 0
    input  logic [Lvl_ROWS-1:0]    req_i,           // One bit per row with any request
    output logic [Lvl_ROWS-1:0]    gnt_o,           // Registered row grant
    output logic [Lvl_ROW_ADD-1:0] xadd_o,          // Index of granted row
    output logic                   grp_release      // Granted row is the last one requesting
);

    logic                   ptr_vld;                // xadd_o points at a row served in this scan
    logic                   found;                  // Candidate row exists
    logic [Lvl_ROW_ADD-1:0] nxt_row;                // Lowest candidate row
    logic                   above_req;              // Some row above the grant still requests

    // Lowest requesting row above the pointer
    always_comb
    begin
        found     = 1'b0;
        nxt_row   = '0;
        above_req = 1'b0;
        for (int i = Lvl_ROWS - 1; i >= 0; i--)     // Descending so the lowest one wins
        begin
            if (req_i[i] && (!ptr_vld || i > int'(xadd_o)))
            begin
                found   = 1'b1;
                nxt_row = Lvl_ROW_ADD'(i);
            end
            if (req_i[i] && i > int'(xadd_o))
                above_req = 1'b1;
        end
    end

    assign grp_release = (|gnt_o) && !above_req;    // Last row of this scan

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_o   <= '0;
            xadd_o  <= '0;
            ptr_vld <= 1'b0;
        end
        else if (refresh_i)
        begin
            gnt_o   <= '0;                          // Drop grant when arbitration stops
            xadd_o  <= '0;
            ptr_vld <= 1'b0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                gnt_o   <= Lvl_ROWS'(1) << nxt_row;
                xadd_o  <= nxt_row;
                ptr_vld <= 1'b1;
            end
            else
            begin
                // Nothing left above, one idle cycle then wrap to the bottom
                gnt_o   <= '0;
                ptr_vld <= 1'b0;
            end
        end
    end

    a_row_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o))
        else $error("Row grant not one-hot");

endmodule

//--- verilog/y_roundrobin.sv
`timescale 1ns/10ps

module y_roundrobin
#(
    parameter int Lvl_COLS    = 4,                  // Number of columns
    parameter int Lvl_COL_ADD = 2                   // Column address width
)
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,        // Step to next requesting column
    input  logic [Lvl_COLS-1:0]    req_i,           // Column requests of the granted row
    output logic [Lvl_COLS-1:0]    gnt_o,           // Registered column grant
    output logic [Lvl_COL_ADD-1:0] yadd_o,          // Index of granted column
    output logic                   grp_release      // Granted column is the highest requesting
);

    logic                   found;
    logic [Lvl_COL_ADD-1:0] nxt_col;
    logic                   above_req;

    // First column on a fresh row, else next one above the last grant
    always_comb
    begin
        found     = 1'b0;
        nxt_col   = '0;
        above_req = 1'b0;
        for (int i = Lvl_COLS - 1; i >= 0; i--)
        begin
            if (req_i[i] && (gnt_o == '0 || i > int'(yadd_o)))
            begin
                found   = 1'b1;
                nxt_col = Lvl_COL_ADD'(i);
            end
            if (req_i[i] && i > int'(yadd_o))
                above_req = 1'b1;
        end
    end

    assign grp_release = (|gnt_o) && !above_req;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_o  <= '0;
            yadd_o <= '0;
        end
        else if (!enable_i)
            gnt_o <= '0;                            // Idle between rows
        else if (found)
        begin
            gnt_o  <= Lvl_COLS'(1) << nxt_col;
            yadd_o <= nxt_col;
        end
        else
            gnt_o <= '0;                            // Row done, FSM goes back to rows
    end

endmodule

//--- verilog/pixel_level.sv
`timescale 1ns/10ps

module pixel_level
#(
    parameter int GROUP_SIZE = 4,                   // Pixels per side
    parameter int Lvl_ADD    = 2                    // Address width of one level
)
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic enable_i,                          // Arbitration enable from CTRL
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][aer_arbiter_pkg::POLARITY-1:0] req_i,
    output logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] gnt_o,
    output logic [Lvl_ADD-1:0] x_add_o,             // Granted row
    output logic [Lvl_ADD-1:0] y_add_o,             // Granted column
    output logic active_o,                          // A column grant was live last cycle
    output logic req_o,                             // Any pixel requesting
    output logic grp_release_o                      // Scan finished
);

    import aer_arbiter_pkg::*;

    logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] pix_req; // Nonzero polarity per pixel
    logic [GROUP_SIZE-1:0] row_req;
    logic [GROUP_SIZE-1:0] col_req;
    logic [GROUP_SIZE-1:0] x_gnt;
    logic [GROUP_SIZE-1:0] y_gnt;
    logic                  x_enable;
    logic                  y_enable;
    logic                  refresh;
    logic                  grp_release_x;
    logic                  grp_release_y;
    arb_state_t            current_state;
    arb_state_t            next_state;

    // --------------------------------------------------
    // Request reduction
    // --------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < GROUP_SIZE; i++)
        begin
            for (int j = 0; j < GROUP_SIZE; j++)
                pix_req[i][j] = |req_i[i][j];
            row_req[i] = |pix_req[i];
        end
    end

    assign col_req = pix_req[x_add_o];              // Columns of the granted row
    assign req_o   = |pix_req;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            current_state <= IDLE;
            active_o      <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            current_state <= next_state;
            active_o      <= |y_gnt;
            grp_release_o <= enable_i && grp_release_x && grp_release_y;
        end
    end

    always_comb
    begin
        next_state = current_state;
        x_enable   = 1'b0;
        y_enable   = 1'b0;
        refresh    = 1'b0;
        case (current_state)
            IDLE:
            begin
                if (enable_i)
                begin
                    x_enable   = 1'b1;              // Start row search
                    next_state = ROW_GRANT;
                end
            end
            ROW_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh    = 1'b1;
                    next_state = IDLE;
                end
                else if (x_gnt != '0)
                begin
                    y_enable   = 1'b1;              // Row held, start column walk
                    next_state = COL_GRANT;
                end
                else
                    x_enable = 1'b1;                // Keep polling rows
            end
            COL_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh    = 1'b1;
                    next_state = IDLE;
                end
                else if (y_gnt == '0)
                begin
                    x_enable   = 1'b1;              // Row exhausted
                    next_state = ROW_GRANT;
                end
                else
                    y_enable = 1'b1;
            end
            default:
                next_state = IDLE;
        endcase
    end

    // Grant grid from the two registered grants
    always_comb
    begin
        gnt_o = '0;
        if (x_gnt != '0 && y_gnt != '0)
            gnt_o[x_add_o][y_add_o] = 1'b1;
    end

    x_roundrobin #(.Lvl_ROWS(GROUP_SIZE), .Lvl_ROW_ADD(Lvl_ADD)) rra_x
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (x_enable),
        .refresh_i   (refresh),
        .req_i       (row_req),
        .gnt_o       (x_gnt),
        .xadd_o      (x_add_o),
        .grp_release (grp_release_x)
    );

    y_roundrobin #(.Lvl_COLS(GROUP_SIZE), .Lvl_COL_ADD(Lvl_ADD)) rra_y
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (y_enable),
        .req_i       (col_req),
        .gnt_o       (y_gnt),
        .yadd_o      (y_add_o),
        .grp_release (grp_release_y)
    );

    // Row and column arbiters together must land on a live request
    a_gnt_on_req: assert property (@(posedge clk_i) disable iff (reset_i)
        (gnt_o & ~pix_req) == '0)
        else $error("Grant on a pixel without request");

endmodule

//--- verilog/aer_timestamp.sv
`timescale 1ns/10ps

module aer_timestamp
#(
    parameter int TS_DIV = 4                        // Clock cycles per timestamp tick
)
(
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              enable_i, // Freeze when low
    output logic [aer_arbiter_pkg::TS_W-1:0]  ts_o
);

    localparam int PRE_W = (TS_DIV > 1) ? $clog2(TS_DIV) : 1;

    logic [PRE_W-1:0] pre_cnt;                      // Prescaler

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pre_cnt <= '0;
            ts_o    <= '0;
        end
        else if (enable_i)
        begin
            if (pre_cnt == PRE_W'(TS_DIV - 1))
            begin
                pre_cnt <= '0;
                ts_o    <= ts_o + 1'b1;             // Wraps at full scale
            end
            else
                pre_cnt <= pre_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/aer_event_queue.sv
`timescale 1ns/10ps

module aer_event_queue
#(
    parameter int GROUP_SIZE = 4,
    parameter int Lvl_ADD    = 2,
    parameter int FIFO_DEPTH = 8                    // Entries, at most 255
)
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] gnt_i,
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][aer_arbiter_pkg::POLARITY-1:0] req_i,
    input  logic [Lvl_ADD-1:0] x_add_i,
    input  logic [Lvl_ADD-1:0] y_add_i,
    input  logic [aer_arbiter_pkg::TS_W-1:0] ts_i,
    input  logic pop_i,                             // Drop head entry
    input  logic clr_ovf_i,                         // Clear sticky overflow
    output aer_arbiter_pkg::aer_event_t head_o,
    output logic [7:0] count_o,
    output logic overflow_o
);

    import aer_arbiter_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    aer_event_t       mem [FIFO_DEPTH];
    aer_event_t       evt;                          // Word for the current grant
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push   = |gnt_i;                         // One event per visible grant
    assign full   = (count_o == 8'(FIFO_DEPTH));
    assign empty  = (count_o == 8'd0);
    assign wr_en  = push && !full;
    assign rd_en  = pop_i && !empty;
    assign head_o = mem[rd_ptr];

    always_comb
    begin
        evt.timestamp = ts_i;
        evt.polarity  = req_i[x_add_i][y_add_i];
        evt.y_addr    = EVT_ADDR_W'(y_add_i);      // Zero-extended
        evt.x_addr    = EVT_ADDR_W'(x_add_i);
    end

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
            mem[wr_ptr] <= evt;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count_o    <= '0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count_o <= count_o + 8'd1;
                2'b01:   count_o <= count_o - 8'd1;
                default: count_o <= count_o;
            endcase
            if (push && full)
                overflow_o <= 1'b1;                 // Event lost, set wins over clear
            else if (clr_ovf_i)
                overflow_o <= 1'b0;
        end
    end

    // Register block gates pops with its copy of the count
    a_no_empty_pop: assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> !empty)
        else $error("Pop on empty event queue");

endmodule

//--- verilog/aer_apb_regs.sv
`timescale 1ns/10ps

module aer_apb_regs
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  aer_arbiter_pkg::apb_req_t   apb_req_i,
    input  aer_arbiter_pkg::aer_event_t head_i,        // Queue head
    input  logic [7:0]                  count_i,       // Queue fill level
    input  logic                        overflow_i,
    input  logic                        grp_release_i, // One pulse per finished scan
    output aer_arbiter_pkg::apb_rsp_t   apb_rsp_o,
    output logic                        enable_o,      // CTRL bit 0
    output logic                        pop_o,
    output logic                        clr_ovf_o,
    output logic                        irq_o          // Queue not empty
);

    import aer_arbiter_pkg::*;

    logic       access;                             // APB access phase
    logic       wr;
    logic       rd;
    logic       addr_ok;
    logic       sts_err;                            // STATUS write touching read-only bits
    reg_addr_t  reg_addr;
    logic [7:0] scan_cnt;

    assign access   = apb_req_i.psel && apb_req_i.penable;
    assign wr       = access && apb_req_i.pwrite;
    assign rd       = access && !apb_req_i.pwrite;
    assign reg_addr = reg_addr_t'(apb_req_i.paddr);
    assign sts_err  = wr && reg_addr == STATUS && (apb_req_i.pwdata & ~32'h100) != '0;

    // --------------------------------------------------
    // Read mux and response
    // --------------------------------------------------
    always_comb
    begin
        addr_ok          = 1'b1;
        apb_rsp_o.prdata = '0;
        case (reg_addr)
            CTRL:    apb_rsp_o.prdata = {31'd0, enable_o};
            STATUS:  apb_rsp_o.prdata = {8'd0, scan_cnt, 7'd0, overflow_i, count_i};
            EVENT:   apb_rsp_o.prdata = {count_i != 8'd0, 5'd0, head_i}; // Bit 31 valid
            default: addr_ok = 1'b0;
        endcase
        apb_rsp_o.pready  = access;                 // No wait states
        apb_rsp_o.pslverr = access && (!addr_ok || sts_err);
    end

    assign pop_o     = rd && reg_addr == EVENT && count_i != 8'd0;
    assign clr_ovf_o = wr && reg_addr == STATUS && apb_req_i.pwdata[8] && !sts_err;
    assign irq_o     = count_i != 8'd0;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            enable_o <= 1'b0;
            scan_cnt <= '0;
        end
        else
        begin
            if (wr && reg_addr == CTRL)
                enable_o <= apb_req_i.pwdata[0];
            if (grp_release_i)
                scan_cnt <= scan_cnt + 8'd1;        // Wraps after 255 scans
        end
    end

endmodule

//--- verilog/aer_sensor_top.sv
`timescale 1ns/10ps

module aer_sensor_top
#(
    parameter int GROUP_SIZE = 4,
    parameter int Lvl_ADD    = 2,
    parameter int TS_DIV     = 4,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0][aer_arbiter_pkg::POLARITY-1:0] pix_req_i,
    input  aer_arbiter_pkg::apb_req_t apb_req_i,
    output logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] pix_gnt_o,
    output aer_arbiter_pkg::apb_rsp_t apb_rsp_o,
    output logic irq_o
);

    import aer_arbiter_pkg::*;

    logic [Lvl_ADD-1:0] x_add;
    logic [Lvl_ADD-1:0] y_add;
    logic [TS_W-1:0]    ts;
    logic [7:0]         count;
    aer_event_t         head;
    logic               grp_release;
    logic               enable;
    logic               pop;
    logic               clr_ovf;
    logic               overflow;

    pixel_level #(.GROUP_SIZE(GROUP_SIZE), .Lvl_ADD(Lvl_ADD)) u_pixel
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable),
        .req_i         (pix_req_i),
        .gnt_o         (pix_gnt_o),
        .x_add_o       (x_add),
        .y_add_o       (y_add),
        .active_o      (),                          // Probed by the bench only
        .req_o         (),
        .grp_release_o (grp_release)
    );

    aer_timestamp #(.TS_DIV(TS_DIV)) u_timestamp
    (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (enable),
        .ts_o     (ts)
    );

    aer_event_queue #(.GROUP_SIZE(GROUP_SIZE), .Lvl_ADD(Lvl_ADD), .FIFO_DEPTH(FIFO_DEPTH)) u_queue
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .gnt_i      (pix_gnt_o),
        .req_i      (pix_req_i),
        .x_add_i    (x_add),
        .y_add_i    (y_add),
        .ts_i       (ts),
        .pop_i      (pop),
        .clr_ovf_i  (clr_ovf),
        .head_o     (head),
        .count_o    (count),
        .overflow_o (overflow)
    );

    aer_apb_regs u_regs
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .apb_req_i     (apb_req_i),
        .head_i        (head),
        .count_i       (count),
        .overflow_i    (overflow),
        .grp_release_i (grp_release),
        .apb_rsp_o     (apb_rsp_o),
        .enable_o      (enable),
        .pop_o         (pop),
        .clr_ovf_o     (clr_ovf),
        .irq_o         (irq_o)
    );

endmodule

//--- bench/aer_sensor_tb.sv
`timescale 1ns/10ps

module aer_sensor_tb;

    import aer_arbiter_pkg::*;

    localparam int GS      = 4;                     // Pixels per side
    localparam int DEPTH   = 8;                     // Event FIFO entries
    localparam int N_STIM  = 6;
    localparam int APB_TO  = 20;                    // Cycles allowed for pready
    localparam int SCAN_TO = 500;                   // Cycles allowed for one scan
    localparam int TS_GAP  = 12;                    // Ticks between scans, timer frozen in between

    typedef logic [GS-1:0][GS-1:0][POLARITY-1:0] grid_t;

    typedef struct packed
    {
        grid_t grid;                                // Polarity per pixel, nonzero requests
        logic  rnd;                                 // Draw polarities with $urandom
        logic  en;                                  // Arbitration on for this entry
        logic  hold;                                // No reads during scan, clear overflow after
        logic  ovf;                                 // Expected overflow flag
    } stim_t;

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    grid_t                 pix_req_i = '0;
    apb_req_t              apb_req_i;
    logic [GS-1:0][GS-1:0] pix_gnt_o;
    apb_rsp_t              apb_rsp_o;
    logic                  irq_o;

    grid_t                 grid_next = '0;          // Grid handed to the pixel model
    logic                  grid_load = 1'b0;
    logic [GS-1:0][GS-1:0] seen = '0;               // Grant seen, clear on next edge
    logic                  ctrl_en = 1'b0;          // Shadow of CTRL enable
    stim_t                 stim [N_STIM];
    aer_event_t            exp_q [$];               // Reference event order
    int                    errors = 0;
    int                    mon_errors = 0;
    int                    timeouts = 0;
    int                    gnt_cnt = 0;             // Cycles with a visible grant
    int                    exp_scan = 0;
    int                    last_ts = 0;

    aer_sensor_top #(.GROUP_SIZE(GS), .Lvl_ADD(2), .TS_DIV(4), .FIFO_DEPTH(DEPTH)) uut
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .pix_req_i (pix_req_i),
        .apb_req_i (apb_req_i),
        .pix_gnt_o (pix_gnt_o),
        .apb_rsp_o (apb_rsp_o),
        .irq_o     (irq_o)
    );

    always #5 clk_i = ~clk_i;                       // 10 ns period

    // --------------------------------------------------
    // Pixel model and grant monitor
    // --------------------------------------------------
    always @(posedge clk_i)
    begin
        if (grid_load)
        begin
            pix_req_i <= grid_next;                 // New pattern
            seen      <= '0;
        end
        else
        begin
            for (int r = 0; r < GS; r++)
            begin
                for (int c = 0; c < GS; c++)
                begin
                    if (seen[r][c])
                    begin
                        pix_req_i[r][c] <= '0;      // Edge after the grant
                        seen[r][c]      <= 1'b0;
                    end
                    else if (pix_gnt_o[r][c])
                        seen[r][c] <= 1'b1;
                end
            end
        end
    end

    always @(negedge clk_i)
    begin : grant_monitor
        logic [GS-1:0][GS-1:0] live;
        for (int r = 0; r < GS; r++)
            for (int c = 0; c < GS; c++)
                live[r][c] = |pix_req_i[r][c];
        if (!reset_i)
        begin
            if ((pix_gnt_o & (pix_gnt_o - 1'b1)) != '0)
            begin
                $display("Grant grid has more than one bit set: %h", pix_gnt_o);
                mon_errors++;
            end
            if ((pix_gnt_o & ~live) != '0)
            begin
                $display("Grant on a pixel without request: %h", pix_gnt_o);
                mon_errors++;
            end
            if (pix_gnt_o != '0 && !ctrl_en)
            begin
                $display("Grant while arbitration is disabled: %h", pix_gnt_o);
                mon_errors++;
            end
            if (pix_gnt_o != '0)
                gnt_cnt++;
        end
    end

    // --------------------------------------------------
    // Tasks
    // --------------------------------------------------
    task automatic compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb_req_t req;
        int       cnt;
        req.psel    = 1'b1;                         // Setup phase
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk_i);
        apb_req_i <= req;
        @(posedge clk_i);
        apb_req_i.penable <= 1'b1;                  // Access phase
        cnt = 0;
        @(negedge clk_i);
        while (!apb_rsp_o.pready && cnt < APB_TO)
        begin
            cnt++;
            @(negedge clk_i);
        end
        if (!apb_rsp_o.pready)
        begin
            $display("Timeout: no pready at offset %h", addr);
            timeouts++;
        end
        rdata = apb_rsp_o.prdata;
        err   = apb_rsp_o.pslverr;
        @(posedge clk_i);
        apb_req_i <= '0;                            // Pop lands on this edge
    endtask

    task automatic apply_grid(input grid_t g);
        @(negedge clk_i);
        grid_next = g;
        grid_load = 1'b1;
        @(negedge clk_i);
        grid_load = 1'b0;
    endtask

    // Row-major order, row pointer restarts at row 0 after each disable
    task automatic build_expected(input grid_t g);
        aer_event_t e;
        exp_q.delete();
        for (int r = 0; r < GS; r++)
        begin
            for (int c = 0; c < GS; c++)
            begin
                if (g[r][c] != '0)
                begin
                    e           = '0;
                    e.x_addr    = EVT_ADDR_W'(r);
                    e.y_addr    = EVT_ADDR_W'(c);
                    e.polarity  = g[r][c];
                    exp_q.push_back(e);
                end
            end
        end
    endtask

    task automatic wait_scan_done();
        int cnt;
        cnt = 0;
        @(negedge clk_i);
        while ((pix_req_i != '0 || pix_gnt_o != '0) && cnt < SCAN_TO)
        begin
            cnt++;
            @(negedge clk_i);
        end
        if (cnt >= SCAN_TO)
        begin
            $display("Timeout: pixel requests were not all granted");
            timeouts++;
        end
    endtask

    task automatic check_status(input int exp_count, input logic exp_ovf);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, STATUS, '0, rdata, err);
        compare_hex("pslverr", err, 0);
        compare_hex("status_count", rdata[7:0], exp_count);
        compare_hex("status_overflow", rdata[8], exp_ovf);
        compare_hex("status_scan", rdata[23:16], exp_scan);
        @(negedge clk_i);
        compare_hex("irq_o", irq_o, exp_count != 0);   // Follows queue not empty
    endtask

    task automatic drain_events(input int kept);
        logic [31:0] rdata;
        logic        err;
        aer_event_t  got;
        aer_event_t  exp;
        int          n_got;
        logic        done;
        n_got = 0;
        done  = 1'b0;
        while (!done && n_got <= DEPTH)
        begin
            apb_xfer(1'b0, EVENT, '0, rdata, err);
            compare_hex("pslverr", err, 0);
            if (!rdata[31])
                done = 1'b1;                        // Queue empty
            else
            begin
                got = rdata[25:0];
                if (n_got < exp_q.size())
                begin
                    exp = exp_q[n_got];
                    compare_hex("x_addr", got.x_addr, exp.x_addr);
                    compare_hex("y_addr", got.y_addr, exp.y_addr);
                    compare_hex("polarity", got.polarity, exp.polarity);
                end
                if (n_got == 0 && (got.timestamp < last_ts || got.timestamp > last_ts + TS_GAP))
                begin
                    $display("MISMATCH timestamp: got %h, previous %h", got.timestamp, last_ts);
                    errors++;                       // Timer ran while disabled
                end
                else if (got.timestamp < last_ts)
                begin
                    $display("MISMATCH timestamp: got %h, previous %h", got.timestamp, last_ts);
                    errors++;
                end
                last_ts = got.timestamp;
                n_got++;
            end
        end
        compare_hex("event_count", n_got, kept);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin : main
        logic [31:0] rdata;
        logic        err;
        stim_t       st;
        grid_t       g;
        int          kept;
        int          gnt_base;
        reset_i   = 1'b1;
        apb_req_i = '0;
        void'($urandom(32'h8b48));
        // Columns: grid, random polarity, enable, hold, expected overflow
        stim[0] = {32'h0000_1000, 1'b0, 1'b1, 1'b0, 1'b0};   // One pixel x1 y2
        stim[1] = {32'hF003_C00C, 1'b1, 1'b1, 1'b0, 1'b0};   // Spread over all rows
        stim[2] = {32'h0000_0041, 1'b0, 1'b0, 1'b0, 1'b0};   // Arbitration left off
        stim[3] = {32'hFF00_0003, 1'b1, 1'b1, 1'b0, 1'b0};   // Full top row
        stim[4] = {32'h00FF_FFFF, 1'b1, 1'b1, 1'b1, 1'b1};   // 12 requests, overflow
        stim[5] = {32'h03C0_0C30, 1'b1, 1'b1, 1'b0, 1'b0};   // After overflow clear
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        compare_hex("pix_gnt_o", pix_gnt_o, 0);
        compare_hex("irq_o", irq_o, 0);
        compare_hex("current_state", uut.u_pixel.current_state, IDLE);
        compare_hex("active_o", uut.u_pixel.active_o, 0);
        compare_hex("grp_release_o", uut.u_pixel.grp_release_o, 0);

        apb_xfer(1'b1, 8'h0C, 32'h1, rdata, err);       // Invalid offset write
        compare_hex("pslverr", err, 1);
        apb_xfer(1'b0, 8'h10, '0, rdata, err);          // Invalid offset read
        compare_hex("pslverr", err, 1);
        apb_xfer(1'b1, STATUS, 32'h1, rdata, err);      // Read-only STATUS bits
        compare_hex("pslverr", err, 1);
        apb_xfer(1'b0, CTRL, '0, rdata, err);
        compare_hex("pslverr", err, 0);
        compare_hex("ctrl", rdata, 0);                  // Still disabled
        check_status(0, 1'b0);

        for (int k = 0; k < N_STIM; k++)
        begin
            st = stim[k];
            g  = st.grid;
            if (st.rnd)
                for (int r = 0; r < GS; r++)
                    for (int c = 0; c < GS; c++)
                        if (g[r][c] != '0)
                            g[r][c] = POLARITY'($urandom % 3 + 1);
            build_expected(g);
            apply_grid(g);
            compare_hex("req_o", uut.u_pixel.req_o, g != '0);   // Any pixel requesting
            repeat (200) @(posedge clk_i);              // Disabled gap, timer must hold
            gnt_base = gnt_cnt;
            if (st.en)
            begin
                ctrl_en = 1'b1;
                apb_xfer(1'b1, CTRL, 32'h1, rdata, err);
                wait_scan_done();
                apb_xfer(1'b1, CTRL, 32'h0, rdata, err);
                ctrl_en = 1'b0;
                if (exp_q.size() > 0)
                    exp_scan++;                         // One release per scan
            end
            else
            begin
                repeat (50) @(posedge clk_i);
                exp_q.delete();                         // Nothing may be granted
                apply_grid('0);
            end
            compare_hex("grant_count", gnt_cnt - gnt_base, exp_q.size());
            kept = (exp_q.size() > DEPTH) ? DEPTH : exp_q.size();
            check_status(kept, st.ovf);
            drain_events(kept);
            if (st.hold)
            begin
                apb_xfer(1'b1, STATUS, 32'h100, rdata, err);
                compare_hex("pslverr", err, 0);
            end
            check_status(0, 1'b0);
        end

        $display("Errors: %0d checks, %0d monitor, %0d timeouts", errors, mon_errors, timeouts);
        if (errors == 0 && mon_errors == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- filelist.f
verilog/aer_arbiter_pkg.sv
verilog/x_roundrobin.sv
verilog/y_roundrobin.sv
verilog/pixel_level.sv
verilog/aer_timestamp.sv
verilog/aer_event_queue.sv
verilog/aer_apb_regs.sv
verilog/aer_sensor_top.sv
bench/aer_sensor_tb.sv
